// File: design/bmem_pkg.sv
// cache-side view of the bridge
// one request word per cycle from the cache, 64-bit beats back
package bmem_pkg;

    // byte address from the cache
    localparam int BMEM_ADDR_W = 32;

    // one cache beat
    localparam int BMEM_DATA_W = 64;

    // beats in one cache line burst
    localparam int BURST_BEATS = 4;

    // enough bits to count the beats of one burst
    localparam int BEAT_CNT_W = $clog2(BURST_BEATS);

    // cache request, sampled every cycle
    // read wins when both strobes are up
    // wdata is swapped by the cache after each high half is taken
    typedef struct packed {
        logic [BMEM_ADDR_W-1:0] addr;
        // level, held until the bridge accepts
        logic                   read;
        // level, held until after the write acknowledge
        logic                   write;
        logic [BMEM_DATA_W-1:0] wdata;
    } bmem_req_t;

endpackage

// File: design/link_pkg.sv
// far-memory link, one flag pair plus payload per word
// words travel through the request and response FIFOs
package link_pkg;

    // payload of one link word
    localparam int LINK_PAYLOAD_W = 32;

    // payload words in one burst, two per cache beat
    localparam int WORDS_PER_BURST = 8;

    // small on purpose so the request side can fill up
    localparam int LINK_FIFO_DEPTH = 4;

    // fifo pointer and occupancy widths
    localparam int LINK_PTR_W = $clog2(LINK_FIFO_DEPTH);
    localparam int LINK_CNT_W = $clog2(LINK_FIFO_DEPTH + 1);

    // write phase counter, runs past the data words
    // WORDS_PER_BURST means waiting for ack, one more means waiting for strobe drop
    localparam int WORD_CNT_W = $clog2(WORDS_PER_BURST + 2);

    // link word
    // request side: header carries the address, data words carry wr set
    // response side: rd set is read data, wr set is a write acknowledge
    typedef struct packed {
        logic                      wr;
        logic                      rd;
        logic [LINK_PAYLOAD_W-1:0] payload;
    } link_word_t;

endpackage

// File: design/link_fifo.sv
`timescale 1ns/1ps

// single-clock show-ahead fifo of link words
module link_fifo
    import link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // write side
    input  logic       push,
    input  link_word_t push_word,
    output logic       full,
    // read side, head valid while empty is low
    input  logic       pop,
    output link_word_t head_word,
    output logic       empty
);

    // entry storage
    link_word_t            mem [LINK_FIFO_DEPTH];
    logic [LINK_PTR_W-1:0] wr_ptr;
    logic [LINK_PTR_W-1:0] rd_ptr;
    logic [LINK_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    // circular pointer advance
    function automatic logic [LINK_PTR_W-1:0] ptr_inc(input logic [LINK_PTR_W-1:0] p);
        return (p == LINK_PTR_W'(LINK_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // push while full and pop while empty are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == LINK_CNT_W'(LINK_FIFO_DEPTH));
    assign empty = (count == '0);

    // show-ahead, head follows the read pointer
    assign head_word = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/burst_requester.sv
`timescale 1ns/1ps

// cache burst sequencer
// turns one cache request into a header word, plus eight data words for a write,
// then tracks the answer coming back through the assembler
module burst_requester
    import bmem_pkg::*;
    import link_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // cache request
    input  bmem_req_t              bmem_req,
    // request fifo write side
    input  logic                   req_full,
    output logic                   req_push,
    output link_word_t             req_word,
    // from the read assembler
    input  logic                   beat_done,
    input  logic                   wr_ack,
    // to the cache
    output logic                   bmem_ready,
    output logic [BMEM_ADDR_W-1:0] bmem_raddr,
    output logic                   bmem_whalf
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_RHDR,
        ST_READ_WAIT,
        ST_SEND_WHDR,
        ST_WRITE_DATA
    } state_e;

    state_e                 state;
    state_e                 next_state;
    logic [BMEM_ADDR_W-1:0] addr_q;
    logic [BEAT_CNT_W-1:0]  beat_cnt;
    logic [WORD_CNT_W-1:0]  word_cnt;
    logic                   latch_addr;
    logic                   beat_inc;
    logic                   word_inc;

    // address captured at acceptance, valid through the whole operation
    always_ff @(posedge clk) begin
        if (latch_addr) begin
            addr_q <= bmem_req.addr;
        end
    end

    assign bmem_raddr = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
            word_cnt <= '0;
        end else begin
            state <= next_state;
            // counters start fresh for every operation
            if (state == ST_IDLE) begin
                beat_cnt <= '0;
                word_cnt <= '0;
            end else begin
                if (beat_inc) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
                if (word_inc) begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        req_push   = 1'b0;
        req_word   = '0;
        bmem_ready = 1'b0;
        bmem_whalf = 1'b0;
        latch_addr = 1'b0;
        beat_inc   = 1'b0;
        word_inc   = 1'b0;
        unique case (state)
            ST_IDLE: begin
                bmem_ready = 1'b1;
                // read has priority
                if (bmem_req.read) begin
                    latch_addr = 1'b1;
                    next_state = ST_SEND_RHDR;
                end else if (bmem_req.write) begin
                    latch_addr = 1'b1;
                    next_state = ST_SEND_WHDR;
                end
            end
            ST_SEND_RHDR: begin
                // header, read flag only
                req_word = '{wr: 1'b0, rd: 1'b1, payload: addr_q};
                if (!req_full) begin
                    req_push   = 1'b1;
                    next_state = ST_READ_WAIT;
                end
            end
            ST_READ_WAIT: begin
                // done on the last beat
                if (beat_done) begin
                    beat_inc = 1'b1;
                    if (beat_cnt == BEAT_CNT_W'(BURST_BEATS - 1)) begin
                        next_state = ST_IDLE;
                    end
                end
            end
            ST_SEND_WHDR: begin
                // header, write flag only
                req_word = '{wr: 1'b1, rd: 1'b0, payload: addr_q};
                if (!req_full) begin
                    req_push   = 1'b1;
                    next_state = ST_WRITE_DATA;
                end
            end
            ST_WRITE_DATA: begin
                if (word_cnt < WORD_CNT_W'(WORDS_PER_BURST)) begin
                    // even words low half, odd words high half
                    req_word.wr      = 1'b1;
                    req_word.payload = word_cnt[0]
                        ? bmem_req.wdata[LINK_PAYLOAD_W +: LINK_PAYLOAD_W]
                        : bmem_req.wdata[0 +: LINK_PAYLOAD_W];
                    // stalled on full, hold the word and keep whalf low
                    if (!req_full) begin
                        req_push   = 1'b1;
                        bmem_whalf = word_cnt[0];
                        word_inc   = 1'b1;
                    end
                end else if (word_cnt == WORD_CNT_W'(WORDS_PER_BURST)) begin
                    // one-cycle ready marks the end of the write
                    if (wr_ack) begin
                        bmem_ready = 1'b1;
                        word_inc   = 1'b1;
                    end
                end else if (!bmem_req.write) begin
                    // cache has let go of the write
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

endmodule

// File: design/read_assembler.sv
`timescale 1ns/1ps

// response side
// drains the response fifo, pairs read words into beats, flags write acks
module read_assembler
    import bmem_pkg::*;
    import link_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // response fifo read side
    input  logic                   rsp_empty,
    input  link_word_t             rsp_word,
    output logic                   rsp_pop,
    // to the cache
    output logic [BMEM_DATA_W-1:0] bmem_rdata,
    output logic                   bmem_rvalid,
    // to the requester
    output logic                   beat_done,
    output logic                   wr_ack
);

    logic [LINK_PAYLOAD_W-1:0] lo_q;
    logic                      hi_next;
    logic                      rvalid_q;
    logic                      ack_q;

    // take every word as soon as it shows up
    assign rsp_pop = !rsp_empty;

    // lower half store and full beat register
    always_ff @(posedge clk) begin
        if (rsp_pop && rsp_word.rd) begin
            if (hi_next) begin
                bmem_rdata <= {rsp_word.payload, lo_q};
            end else begin
                lo_q <= rsp_word.payload;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_next  <= 1'b0;
            rvalid_q <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            // single-cycle pulses
            rvalid_q <= rsp_pop && rsp_word.rd && hi_next;
            ack_q    <= rsp_pop && rsp_word.wr && !rsp_word.rd;
            // half toggle, lower word arrives first
            if (rsp_pop && rsp_word.rd) begin
                hi_next <= !hi_next;
            end
        end
    end

    // cache valid and requester beat count share one pulse
    assign bmem_rvalid = rvalid_q;
    assign beat_done   = rvalid_q;
    assign wr_ack      = ack_q;

endmodule

// File: design/mem_bridge.sv
`timescale 1ns/1ps

// cache to far-memory bridge
// requester -> request fifo -> link, link -> response fifo -> assembler
module mem_bridge
    import bmem_pkg::*;
    import link_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // cache side
    input  bmem_req_t              bmem_req,
    output logic                   bmem_ready,
    output logic [BMEM_ADDR_W-1:0] bmem_raddr,
    output logic [BMEM_DATA_W-1:0] bmem_rdata,
    output logic                   bmem_rvalid,
    output logic                   bmem_whalf,
    // link request side, far memory pops
    output link_word_t             link_req_word,
    output logic                   link_req_empty,
    input  logic                   link_req_pop,
    // link response side, far memory pushes
    input  link_word_t             link_rsp_word,
    input  logic                   link_rsp_push,
    output logic                   link_rsp_full
);

    // requester to request fifo
    logic       req_push;
    link_word_t req_word;
    logic       req_full;
    // response fifo to assembler
    logic       rsp_pop;
    link_word_t rsp_word;
    logic       rsp_empty;
    // assembler back to requester
    logic       beat_done;
    logic       wr_ack;

    burst_requester u_requester (
        .clk        (clk),
        .rst        (rst),
        .bmem_req   (bmem_req),
        .req_full   (req_full),
        .req_push   (req_push),
        .req_word   (req_word),
        .beat_done  (beat_done),
        .wr_ack     (wr_ack),
        .bmem_ready (bmem_ready),
        .bmem_raddr (bmem_raddr),
        .bmem_whalf (bmem_whalf)
    );

    link_fifo u_req_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (req_push),
        .push_word (req_word),
        .full      (req_full),
        .pop       (link_req_pop),
        .head_word (link_req_word),
        .empty     (link_req_empty)
    );

    link_fifo u_rsp_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (link_rsp_push),
        .push_word (link_rsp_word),
        .full      (link_rsp_full),
        .pop       (rsp_pop),
        .head_word (rsp_word),
        .empty     (rsp_empty)
    );

    read_assembler u_assembler (
        .clk         (clk),
        .rst         (rst),
        .rsp_empty   (rsp_empty),
        .rsp_word    (rsp_word),
        .rsp_pop     (rsp_pop),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid),
        .beat_done   (beat_done),
        .wr_ack      (wr_ack)
    );

endmodule

// File: verif/link_responder.sv
`timescale 1ns/1ps

// far-memory model on the link side
// pops request words at throttled times, answers from a fixed rule
module link_responder
    import link_pkg::*;
(
    input  logic       clk,
    // pop rarely so the request fifo fills
    input  logic       slow,
    input  link_word_t req_word,
    input  logic       req_empty,
    output logic       req_pop,
    output link_word_t rsp_word,
    output logic       rsp_push,
    input  logic       rsp_full
);

    localparam int LOG_DEPTH = 128;

    // every popped request word, in order
    link_word_t  req_log [LOG_DEPTH];
    int          log_len;
    // answers waiting for room in the response fifo
    link_word_t  rsp_q [$];
    // data words still owed by the current write
    int          wr_left;
    logic [31:0] rng;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        logic       take;
        link_word_t rsp;
        req_pop  <= 1'b0;
        rsp_push <= 1'b0;
        rsp_word <= '0;
        log_len = 0;
        wr_left = 0;
        rng     = 32'h5dd5;
        forever begin
            @(negedge clk);
            rng  = lcg_next(rng);
            // slow pops one cycle in eight, otherwise three in four
            take = !req_empty && (slow ? (rng[18:16] == 3'd0) : (rng[17:16] != 2'd0));
            req_pop <= take;
            if (take) begin
                if (log_len < LOG_DEPTH) begin
                    req_log[log_len] = req_word;
                    log_len++;
                end
                if (wr_left > 0) begin
                    wr_left--;
                    // last data word in, acknowledge the write
                    if (wr_left == 0) begin
                        rsp = '{wr: 1'b1, rd: 1'b0, payload: '0};
                        rsp_q.push_back(rsp);
                    end
                end else if (req_word.rd) begin
                    // read header, word k is the address plus k
                    for (int k = 0; k < WORDS_PER_BURST; k++) begin
                        rsp = '{wr: 1'b0, rd: 1'b1, payload: req_word.payload + 32'(k)};
                        rsp_q.push_back(rsp);
                    end
                end else if (req_word.wr) begin
                    wr_left = WORDS_PER_BURST;
                end
            end
            // no push while the response fifo is full
            if (rsp_q.size() > 0 && !rsp_full) begin
                rsp = rsp_q.pop_front();
                rsp_word <= rsp;
                rsp_push <= 1'b1;
            end else begin
                rsp_push <= 1'b0;
            end
        end
    end

endmodule

// File: verif/mem_bridge_props.sv
`timescale 1ns/1ps

// protocol rules on the bridge top level
module mem_bridge_props (
    input logic clk,
    input logic rst,
    input logic bmem_ready,
    input logic bmem_rvalid,
    input logic bmem_whalf,
    input logic link_req_pop,
    input logic link_req_empty
);

    // failures so far, read back at the end of the run
    int assert_fails = 0;

    // end of a read beat and end of a write never share a cycle
    a_rvalid_ready: assert property (@(posedge clk) disable iff (rst)
        !(bmem_rvalid && bmem_ready))
        else begin
            assert_fails++;
            $error("bmem_rvalid and bmem_ready high in the same cycle");
        end

    // no half is taken while idle or acknowledging
    a_whalf_ready: assert property (@(posedge clk) disable iff (rst)
        !(bmem_whalf && bmem_ready))
        else begin
            assert_fails++;
            $error("bmem_whalf high while bmem_ready is high");
        end

    // far memory only pops a non-empty request fifo
    a_pop_empty: assert property (@(posedge clk) disable iff (rst)
        !(link_req_pop && link_req_empty))
        else begin
            assert_fails++;
            $error("link_req_pop while link_req_empty is high");
        end

endmodule

bind mem_bridge mem_bridge_props u_props (
    .clk            (clk),
    .rst            (rst),
    .bmem_ready     (bmem_ready),
    .bmem_rvalid    (bmem_rvalid),
    .bmem_whalf     (bmem_whalf),
    .link_req_pop   (link_req_pop),
    .link_req_empty (link_req_empty)
);

// File: verif/mem_bridge_tb.sv
`timescale 1ns/1ps

// testbench for the cache to far-memory bridge
module mem_bridge_tb
    import bmem_pkg::*;
    import link_pkg::*;
();

    // one table row per operation
    typedef struct packed {
        logic                   is_read;
        // responder pops rarely
        logic                   slow;
        logic [BMEM_ADDR_W-1:0] addr;
        // mixed into the write data
        logic [31:0]            tag;
    } op_t;

    localparam int N_OPS          = 8;
    localparam int TIMEOUT_CYCLES = N_OPS * 200;

    // rows 0 to 3 one behavior each and rows 4 to 7 back to back
    localparam op_t OPS [N_OPS] = '{
        '{1'b0, 1'b0, 32'h0000_1000, 32'h0000_0000},
        '{1'b1, 1'b0, 32'h0000_2000, 32'h0000_0000},
        '{1'b0, 1'b1, 32'h0000_3000, 32'hA5A5_0000},
        '{1'b1, 1'b1, 32'h0000_4000, 32'h0000_0000},
        '{1'b1, 1'b0, 32'h8000_5000, 32'h0000_0000},
        '{1'b0, 1'b0, 32'h0000_6000, 32'h0F0F_0F0F},
        '{1'b0, 1'b1, 32'hFFFF_FFF0, 32'h1234_5678},
        '{1'b1, 1'b0, 32'hFFFF_FFFC, 32'h0000_0000}
    };

    string names [N_OPS] = '{
        "write burst", "read burst", "write backpressure", "read backpressure",
        "mixed read", "mixed write", "mixed write slow", "mixed read wrap"
    };

    logic                   clk;
    logic                   rst;
    logic                   slow;
    bmem_req_t              bmem_req;
    logic                   bmem_ready;
    logic [BMEM_ADDR_W-1:0] bmem_raddr;
    logic [BMEM_DATA_W-1:0] bmem_rdata;
    logic                   bmem_rvalid;
    logic                   bmem_whalf;
    link_word_t             link_req_word;
    logic                   link_req_empty;
    logic                   link_req_pop;
    link_word_t             link_rsp_word;
    logic                   link_rsp_push;
    logic                   link_rsp_full;

    // beats handed to the bridge by the current write
    logic [BMEM_DATA_W-1:0] sent_beats [BURST_BEATS];
    logic [31:0]            rng;
    int                     cycles;
    int                     test_errs;
    int                     pass_count;
    int                     fail_count;

    mem_bridge u_mem_bridge (
        .clk            (clk),
        .rst            (rst),
        .bmem_req       (bmem_req),
        .bmem_ready     (bmem_ready),
        .bmem_raddr     (bmem_raddr),
        .bmem_rdata     (bmem_rdata),
        .bmem_rvalid    (bmem_rvalid),
        .bmem_whalf     (bmem_whalf),
        .link_req_word  (link_req_word),
        .link_req_empty (link_req_empty),
        .link_req_pop   (link_req_pop),
        .link_rsp_word  (link_rsp_word),
        .link_rsp_push  (link_rsp_push),
        .link_rsp_full  (link_rsp_full)
    );

    link_responder u_responder (
        .clk       (clk),
        .slow      (slow),
        .req_word  (link_req_word),
        .req_empty (link_req_empty),
        .req_pop   (link_req_pop),
        .rsp_word  (link_rsp_word),
        .rsp_push  (link_rsp_push),
        .rsp_full  (link_rsp_full)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic make_beat(input logic [31:0] tag, output logic [BMEM_DATA_W-1:0] beat);
        rng = lcg_next(rng);
        beat[63:32] = rng ^ tag;
        rng = lcg_next(rng);
        beat[31:0] = rng;
    endtask

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s: got 0x%h, expected 0x%h", sig, got, exp);
        test_errs++;
    endtask

    // one logged request word against its flags and payload
    task automatic check_link_word(input int idx, input logic [1:0] exp_flags,
                                   input logic [31:0] exp_payload);
        link_word_t w;
        w = u_responder.req_log[idx];
        if ({w.wr, w.rd} !== exp_flags) begin
            report_mismatch("link_req_word.{wr,rd}", 64'({w.wr, w.rd}), 64'(exp_flags));
        end
        if (w.payload !== exp_payload) begin
            report_mismatch("link_req_word.payload", 64'(w.payload), 64'(exp_payload));
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
    endtask

    task automatic run_write(input op_t op);
        int   base;
        int   highs;
        int   pulses;
        logic change_due;
        logic seen_whalf;
        base       = u_responder.log_len;
        highs      = 0;
        pulses     = 0;
        change_due = 1'b0;
        for (int b = 0; b < BURST_BEATS; b++) begin
            make_beat(op.tag, sent_beats[b]);
        end
        bmem_req.addr  = op.addr;
        bmem_req.read  = 1'b0;
        bmem_req.write = 1'b1;
        bmem_req.wdata = sent_beats[0];
        @(negedge clk);
        // swap data the cycle after each high half is taken
        while (pulses == 0) begin
            seen_whalf = bmem_whalf;
            if (change_due) begin
                bmem_req.wdata = (highs < BURST_BEATS) ? sent_beats[highs] : '0;
                change_due = 1'b0;
            end
            if (seen_whalf) begin
                highs++;
                change_due = 1'b1;
            end
            if (bmem_ready) begin
                pulses++;
                if (highs != BURST_BEATS) begin
                    report_mismatch("bmem_whalf high count", 64'(highs), 64'(BURST_BEATS));
                end
            end
            @(negedge clk);
        end
        // ready stays low while the write strobe is held
        for (int h = 0; h < 2; h++) begin
            if (bmem_ready) begin
                pulses++;
            end
            @(negedge clk);
        end
        bmem_req.write = 1'b0;
        if (pulses != 1) begin
            report_mismatch("bmem_ready pulse count", 64'(pulses), 64'd1);
        end
        if (u_responder.log_len != base + 1 + WORDS_PER_BURST) begin
            $display("request log holds %0d words for the write, expected %0d",
                     u_responder.log_len - base, 1 + WORDS_PER_BURST);
            test_errs++;
        end else begin
            check_link_word(base, 2'b10, op.addr);
            // low half then high half of each beat
            for (int k = 0; k < WORDS_PER_BURST; k++) begin
                check_link_word(base + 1 + k, 2'b10, (k % 2 == 1)
                    ? sent_beats[k / 2][63:32] : sent_beats[k / 2][31:0]);
            end
        end
    endtask

    task automatic run_read(input op_t op);
        int                     base;
        int                     beats;
        logic [BMEM_DATA_W-1:0] exp;
        base           = u_responder.log_len;
        beats          = 0;
        bmem_req.addr  = op.addr;
        bmem_req.read  = 1'b1;
        bmem_req.write = 1'b0;
        bmem_req.wdata = '0;
        @(negedge clk);
        bmem_req.read = 1'b0;
        while (beats < BURST_BEATS) begin
            if (bmem_rvalid) begin
                // upper word is address plus 2j+1 and lower word address plus 2j
                exp = {op.addr + 32'(2 * beats + 1), op.addr + 32'(2 * beats)};
                if (bmem_rdata !== exp) begin
                    report_mismatch("bmem_rdata", bmem_rdata, exp);
                end
                if (bmem_raddr !== op.addr) begin
                    report_mismatch("bmem_raddr", 64'(bmem_raddr), 64'(op.addr));
                end
                beats++;
            end
            @(negedge clk);
        end
        // requester back to idle on the cycle after the fourth beat
        if (bmem_ready !== 1'b1) begin
            report_mismatch("bmem_ready after last beat", 64'(bmem_ready), 64'd1);
        end
        if (u_responder.log_len != base + 1) begin
            $display("request log holds %0d words for the read, expected 1",
                     u_responder.log_len - base);
            test_errs++;
        end else begin
            check_link_word(base, 2'b01, op.addr);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit from the table length
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: table not finished within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        slow      <= 1'b0;
        bmem_req   = '0;
        rng        = 32'h5dd5;
        pass_count = 0;
        fail_count = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle state straight out of reset
        test_errs = 0;
        if (bmem_ready !== 1'b1) begin
            report_mismatch("bmem_ready", 64'(bmem_ready), 64'd1);
        end
        if (bmem_rvalid !== 1'b0) begin
            report_mismatch("bmem_rvalid", 64'(bmem_rvalid), 64'd0);
        end
        if (bmem_whalf !== 1'b0) begin
            report_mismatch("bmem_whalf", 64'(bmem_whalf), 64'd0);
        end
        if (link_req_empty !== 1'b1) begin
            report_mismatch("link_req_empty", 64'(link_req_empty), 64'd1);
        end
        finish_test("reset state");

        // next row starts as soon as ready is seen
        for (int r = 0; r < N_OPS; r++) begin
            test_errs = 0;
            slow     <= OPS[r].slow;
            while (bmem_ready !== 1'b1) begin
                @(negedge clk);
            end
            if (OPS[r].is_read) begin
                run_read(OPS[r]);
            end else begin
                run_write(OPS[r]);
            end
            finish_test(names[r]);
        end

        if (u_mem_bridge.u_props.assert_fails != 0) begin
            $display("%0d protocol assertions failed", u_mem_bridge.u_props.assert_fails);
            fail_count++;
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
design/bmem_pkg.sv
design/link_pkg.sv
design/link_fifo.sv
design/burst_requester.sv
design/read_assembler.sv
design/mem_bridge.sv
verif/link_responder.sv
verif/mem_bridge_props.sv
verif/mem_bridge_tb.sv

// File: Makefile
SRCS := $(wildcard design/*.sv verif/*.sv)

obj_dir/Vmem_bridge_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module mem_bridge_tb \
		-Mdir obj_dir -o Vmem_bridge_tb

run: obj_dir/Vmem_bridge_tb
	./obj_dir/Vmem_bridge_tb +verilator+error+limit+100 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
